// File: rtl/fetch_defs.svh
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// byte address width seen by fetch and the RAM
`define FETCH_ADDR_W 32

// instruction word width, four bytes
`define FETCH_INST_W 32

// number of bytes in the instruction RAM
// only the low address bits select an entry
`define FETCH_RAM_DEPTH 256

// program counter value after reset
`define FETCH_RESET_PC 32'h0000_0000

`endif

// File: rtl/fetch_pkg.sv
`default_nettype none

`include "fetch_defs.svh"

package fetch_pkg;

    // fetch unit states
    // IDLE waits for stall low, ISSUE sends the byte addresses,
    // DRAIN waits for the last byte, HOLD offers the finished word
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        ISSUE = 2'd1,
        DRAIN = 2'd2,
        HOLD  = 2'd3
    } fetch_state_e;

    // word handed from fetch to the decode-side register
    typedef struct packed {
        logic [`FETCH_ADDR_W-1:0] pc;
        logic [`FETCH_INST_W-1:0] inst;
    } fetched_inst_s;

endpackage

`default_nettype wire

// File: rtl/byte_mem_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

interface byte_mem_if;

    // read request and its byte address
    logic                     rd_en;
    logic [`FETCH_ADDR_W-1:0] rd_addr;

    // byte returned one cycle after rd_en
    logic [7:0]               rd_data;
    logic                     rd_valid;

    modport fetcher (
        output rd_en,
        output rd_addr,
        input  rd_data,
        input  rd_valid
    );

    modport memory (
        input  rd_en,
        input  rd_addr,
        output rd_data,
        output rd_valid
    );

endinterface

`default_nettype wire

// File: rtl/inst_fetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module inst_fetch (
    input  logic                     clk,
    input  logic                     reset_i,
    input  logic                     stall_i,
    input  logic                     branch_i,
    input  logic [`FETCH_ADDR_W-1:0] branch_addr_i,
    byte_mem_if.fetcher              mem,
    output fetch_pkg::fetched_inst_s word_o,
    output logic                     word_valid_o
);

    fetch_pkg::fetch_state_e state_q;

    // pc of the instruction being fetched or held
    logic [`FETCH_ADDR_W-1:0] pc_q;
    logic [`FETCH_ADDR_W-1:0] seq_pc;

    // read side towards the RAM
    logic                     rd_en_q;
    logic [`FETCH_ADDR_W-1:0] rd_addr_q;
    logic [1:0]               issue_cnt_q;

    // return side and word assembly
    logic [1:0]               recv_cnt_q;
    logic [`FETCH_INST_W-1:0] asm_q;
    logic                     byte_in;
    logic                     start_seq;
    logic                     start_idle;

    assign seq_pc = pc_q + 4;

    // bytes only count while a fetch is live, stale returns after a branch drop here
    assign byte_in = mem.rd_valid &&
                     (state_q == fetch_pkg::ISSUE || state_q == fetch_pkg::DRAIN);

    // a new fetch begins from IDLE at pc, or from HOLD at pc plus 4
    assign start_idle = (state_q == fetch_pkg::IDLE) && !stall_i;
    assign start_seq  = (state_q == fetch_pkg::HOLD) && !stall_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q     <= fetch_pkg::IDLE;
            pc_q        <= `FETCH_RESET_PC;
            rd_en_q     <= 1'b0;
            issue_cnt_q <= 2'd0;
            recv_cnt_q  <= 2'd0;
        end else if (branch_i) begin
            // redirect wins over stall and over any fetch in flight
            state_q     <= fetch_pkg::IDLE;
            pc_q        <= branch_addr_i;
            rd_en_q     <= 1'b0;
            issue_cnt_q <= 2'd0;
            recv_cnt_q  <= 2'd0;
        end else begin
            if (byte_in) begin
                recv_cnt_q <= recv_cnt_q + 2'd1;
            end
            case (state_q)
                fetch_pkg::IDLE: begin
                    if (start_idle) begin
                        state_q <= fetch_pkg::ISSUE;
                        rd_en_q <= 1'b1;
                    end
                end
                fetch_pkg::ISSUE: begin
                    // counter wraps back to zero after the fourth byte
                    issue_cnt_q <= issue_cnt_q + 2'd1;
                    if (issue_cnt_q == 2'd3) begin
                        rd_en_q <= 1'b0;
                        state_q <= fetch_pkg::DRAIN;
                    end
                end
                fetch_pkg::DRAIN: begin
                    if (byte_in && recv_cnt_q == 2'd3) begin
                        state_q <= fetch_pkg::HOLD;
                    end
                end
                fetch_pkg::HOLD: begin
                    // word leaves this cycle unless decode is stalled
                    if (start_seq) begin
                        state_q <= fetch_pkg::ISSUE;
                        pc_q    <= seq_pc;
                        rd_en_q <= 1'b1;
                    end
                end
                default: begin
                    state_q <= fetch_pkg::IDLE;
                    rd_en_q <= 1'b0;
                end
            endcase
        end
    end

    // byte address walks pc, pc+1, pc+2, pc+3
    always_ff @(posedge clk) begin
        if (start_idle) begin
            rd_addr_q <= pc_q;
        end else if (start_seq) begin
            rd_addr_q <= seq_pc;
        end else if (state_q == fetch_pkg::ISSUE) begin
            rd_addr_q <= rd_addr_q + 1;
        end
    end

    // little endian, first byte ends up in the low lane after four shifts
    always_ff @(posedge clk) begin
        if (byte_in) begin
            asm_q <= {mem.rd_data, asm_q[`FETCH_INST_W-1:8]};
        end
    end

    assign mem.rd_en   = rd_en_q;
    assign mem.rd_addr = rd_addr_q;

    assign word_o.pc    = pc_q;
    assign word_o.inst  = asm_q;
    assign word_valid_o = (state_q == fetch_pkg::HOLD);

    // a cancelled fetch must never surface as a word
    assert property (@(posedge clk) disable iff (reset_i)
        branch_i |=> !word_valid_o)
        else $error("inst_fetch: word_valid_o high right after a branch");

    assert property (@(posedge clk) disable iff (reset_i)
        mem.rd_en |-> state_q == fetch_pkg::ISSUE)
        else $error("inst_fetch: read request outside ISSUE");

endmodule

`default_nettype wire

// File: rtl/inst_byte_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module inst_byte_ram (
    input  logic                     clk,
    input  logic                     reset_i,
    byte_mem_if.memory               mem,
    input  logic                     load_we_i,
    input  logic [`FETCH_ADDR_W-1:0] load_addr_i,
    input  logic [7:0]               load_data_i
);

    localparam int IDX_W = $clog2(`FETCH_RAM_DEPTH);

    logic [7:0]       ram [`FETCH_RAM_DEPTH];
    logic [IDX_W-1:0] wr_idx;
    logic [IDX_W-1:0] rd_idx;
    logic [7:0]       rd_data_q;
    logic             rd_valid_q;

    // upper address bits wrap onto the array
    assign wr_idx = load_addr_i[IDX_W-1:0];
    assign rd_idx = mem.rd_addr[IDX_W-1:0];

    // load port
    always_ff @(posedge clk) begin
        if (load_we_i) begin
            ram[wr_idx] <= load_data_i;
        end
    end

    // registered read, data only moves on a request
    always_ff @(posedge clk) begin
        if (mem.rd_en) begin
            rd_data_q <= ram[rd_idx];
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= mem.rd_en;
        end
    end

    assign mem.rd_data  = rd_data_q;
    assign mem.rd_valid = rd_valid_q;

    // loading and fetching the same byte at once has no defined result
    assert property (@(posedge clk) disable iff (reset_i)
        !(load_we_i && mem.rd_en && wr_idx == rd_idx))
        else $error("inst_byte_ram: write and read hit address %0h together", wr_idx);

endmodule

`default_nettype wire

// File: rtl/if_id_reg.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module if_id_reg (
    input  logic                     clk,
    input  logic                     reset_i,
    input  logic                     stall_i,
    input  logic                     flush_i,
    input  fetch_pkg::fetched_inst_s word_i,
    input  logic                     word_valid_i,
    output logic                     id_valid_o,
    output logic [`FETCH_ADDR_W-1:0] id_pc_o,
    output logic [`FETCH_INST_W-1:0] id_inst_o
);

    logic                     valid_q;
    logic [`FETCH_ADDR_W-1:0] pc_q;
    logic [`FETCH_INST_W-1:0] inst_q;
    logic                     take;

    // handoff happens only when decode is not stalled
    assign take = word_valid_i && !stall_i;

    // flush beats both load and hold
    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            valid_q <= 1'b0;
        end else if (!stall_i) begin
            valid_q <= word_valid_i;
        end
    end

    // payload kept as is while stalled
    always_ff @(posedge clk) begin
        if (take && !flush_i) begin
            pc_q   <= word_i.pc;
            inst_q <= word_i.inst;
        end
    end

    assign id_valid_o = valid_q;
    assign id_pc_o    = pc_q;
    assign id_inst_o  = inst_q;

    assert property (@(posedge clk) disable iff (reset_i)
        flush_i |=> !id_valid_o)
        else $error("if_id_reg: id_valid_o still high after flush");

endmodule

`default_nettype wire

// File: rtl/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module fetch_top (
    input  logic                     clk,
    input  logic                     reset_i,
    input  logic                     stall_i,
    input  logic                     branch_i,
    input  logic [`FETCH_ADDR_W-1:0] branch_addr_i,
    input  logic                     load_we_i,
    input  logic [`FETCH_ADDR_W-1:0] load_addr_i,
    input  logic [7:0]               load_data_i,
    output logic                     id_valid_o,
    output logic [`FETCH_ADDR_W-1:0] id_pc_o,
    output logic [`FETCH_INST_W-1:0] id_inst_o
);

    // byte read channel between fetch and RAM
    byte_mem_if mem_bus ();

    fetch_pkg::fetched_inst_s fetch_word;
    logic                     fetch_word_valid;

    inst_fetch u_fetch (
        .clk           (clk),
        .reset_i       (reset_i),
        .stall_i       (stall_i),
        .branch_i      (branch_i),
        .branch_addr_i (branch_addr_i),
        .mem           (mem_bus.fetcher),
        .word_o        (fetch_word),
        .word_valid_o  (fetch_word_valid)
    );

    inst_byte_ram u_ram (
        .clk         (clk),
        .reset_i     (reset_i),
        .mem         (mem_bus.memory),
        .load_we_i   (load_we_i),
        .load_addr_i (load_addr_i),
        .load_data_i (load_data_i)
    );

    // the branch strobe doubles as the flush of the decode register
    if_id_reg u_if_id (
        .clk          (clk),
        .reset_i      (reset_i),
        .stall_i      (stall_i),
        .flush_i      (branch_i),
        .word_i       (fetch_word),
        .word_valid_i (fetch_word_valid),
        .id_valid_o   (id_valid_o),
        .id_pc_o      (id_pc_o),
        .id_inst_o    (id_inst_o)
    );

endmodule

`default_nettype wire

// File: bench/fetch_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module fetch_checker (
    input  logic                     clk,
    input  logic                     reset_i,
    input  logic                     stall_i,
    input  logic                     branch_i,
    input  logic [`FETCH_ADDR_W-1:0] branch_addr_i,
    input  logic                     load_we_i,
    input  logic [`FETCH_ADDR_W-1:0] load_addr_i,
    input  logic [7:0]               load_data_i,
    input  logic                     id_valid_i,
    input  logic [`FETCH_ADDR_W-1:0] id_pc_i,
    input  logic [`FETCH_INST_W-1:0] id_inst_i,
    output int                       error_count_o,
    output int                       item_count_o,
    output logic                     target_pending_o
);

    localparam int IDX_W = $clog2(`FETCH_RAM_DEPTH);

    // shadow of the instruction RAM, filled from the load port
    logic [7:0] image [`FETCH_RAM_DEPTH];

    logic [`FETCH_ADDR_W-1:0] exp_pc;
    logic [`FETCH_INST_W-1:0] exp_inst;
    logic [`FETCH_ADDR_W-1:0] prev_pc;
    logic [`FETCH_INST_W-1:0] prev_inst;
    logic                     prev_valid;
    logic                     prev_stall;
    logic                     prev_branch;
    logic                     new_item;
    logic                     first_seen;
    int                       cycle;
    int                       first_low;

    // lowest address goes to the least significant byte
    function automatic logic [`FETCH_INST_W-1:0] image_word(
        input logic [`FETCH_ADDR_W-1:0] pc
    );
        logic [IDX_W-1:0]         idx;
        logic [`FETCH_INST_W-1:0] w;
        int                       k;
        idx = pc[IDX_W-1:0];
        for (k = 0; k < 4; k++) begin
            w[8*k +: 8] = image[idx];
            idx = idx + 1'b1;
        end
        return w;
    endfunction

    always @(posedge clk) begin
        if (reset_i) begin
            error_count_o    = 0;
            item_count_o     = 0;
            target_pending_o = 1'b0;
            exp_pc           = `FETCH_RESET_PC;
            cycle            = 0;
            first_low        = -1;
            first_seen       = 1'b0;
        end else begin
            cycle = cycle + 1;
            if (load_we_i) begin
                image[load_addr_i[IDX_W-1:0]] = load_data_i;
            end
            if (!stall_i && first_low < 0) begin
                first_low = cycle;
            end

            // outputs seen here were set by the previous edge
            if (prev_branch && id_valid_i) begin
                $display("id_valid_o still high one cycle after a branch at %0t", $time);
                error_count_o = error_count_o + 1;
            end
            if (prev_stall && !prev_branch &&
                (id_pc_i !== prev_pc || id_inst_i !== prev_inst || id_valid_i !== prev_valid)) begin
                $display("decode outputs moved while stall_i was high at %0t", $time);
                error_count_o = error_count_o + 1;
            end

            new_item = id_valid_i && (!prev_valid || id_pc_i !== prev_pc);
            if (new_item) begin
                item_count_o     = item_count_o + 1;
                target_pending_o = 1'b0;
                exp_inst         = image_word(exp_pc);
                if (!first_seen) begin
                    first_seen = 1'b1;
                    // the fetch starts on the edge that first samples stall low
                    if (cycle - first_low - 1 != 6) begin
                        $display("first id_valid_o came %0d cycles after stall_i went low, not 6",
                                 cycle - first_low - 1);
                        error_count_o = error_count_o + 1;
                    end
                end
                if (id_pc_i !== exp_pc) begin
                    $display("ERROR id_pc_o expected %h actual %h", exp_pc, id_pc_i);
                    error_count_o = error_count_o + 1;
                end
                if (id_inst_i !== exp_inst) begin
                    $display("ERROR id_inst_o expected %h actual %h", exp_inst, id_inst_i);
                    error_count_o = error_count_o + 1;
                end
                // resync so one slip is reported once
                exp_pc = id_pc_i + 4;
            end

            if (branch_i) begin
                exp_pc           = branch_addr_i;
                target_pending_o = 1'b1;
            end
        end
        prev_valid  = id_valid_i;
        prev_pc     = id_pc_i;
        prev_inst   = id_inst_i;
        prev_stall  = stall_i;
        prev_branch = branch_i && !reset_i;
    end

endmodule

`default_nettype wire

// File: bench/fetch_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module fetch_tb;

    localparam int CLK_PERIOD = 20;

    logic                     clk;
    logic                     reset_i;
    logic                     stall_i;
    logic                     branch_i;
    logic [`FETCH_ADDR_W-1:0] branch_addr_i;
    logic                     load_we_i;
    logic [`FETCH_ADDR_W-1:0] load_addr_i;
    logic [7:0]               load_data_i;
    logic                     id_valid_o;
    logic [`FETCH_ADDR_W-1:0] id_pc_o;
    logic [`FETCH_INST_W-1:0] id_inst_o;

    int     error_count;
    int     item_count;
    logic   target_pending;
    int     tb_errors;
    int     limit_cycles;
    logic   limit_ready;
    integer seed;

    // records parsed from the stimulus file
    logic [`FETCH_ADDR_W-1:0] img_addr_q [$];
    logic [7:0]               img_data_q [$];
    logic [8*8-1:0]           cmd_op_q [$];
    int                       cmd_a_q [$];
    int                       cmd_b_q [$];

    fetch_top UUT (
        .clk           (clk),
        .reset_i       (reset_i),
        .stall_i       (stall_i),
        .branch_i      (branch_i),
        .branch_addr_i (branch_addr_i),
        .load_we_i     (load_we_i),
        .load_addr_i   (load_addr_i),
        .load_data_i   (load_data_i),
        .id_valid_o    (id_valid_o),
        .id_pc_o       (id_pc_o),
        .id_inst_o     (id_inst_o)
    );

    fetch_checker u_checker (
        .clk              (clk),
        .reset_i          (reset_i),
        .stall_i          (stall_i),
        .branch_i         (branch_i),
        .branch_addr_i    (branch_addr_i),
        .load_we_i        (load_we_i),
        .load_addr_i      (load_addr_i),
        .load_data_i      (load_data_i),
        .id_valid_i       (id_valid_o),
        .id_pc_i          (id_pc_o),
        .id_inst_i        (id_inst_o),
        .error_count_o    (error_count),
        .item_count_o     (item_count),
        .target_pending_o (target_pending)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // background for bytes the image leaves out
    function automatic logic [7:0] fill_byte(input logic [7:0] a);
        return a ^ {a[4:0], a[7:5]} ^ 8'h96;
    endfunction

    task automatic read_stimulus();
        integer           fd;
        integer           n;
        logic [8*8-1:0]   tok;
        logic [8*120-1:0] line_buf;
        logic [31:0]      a;
        logic [31:0]      b;
        logic             done;
        fd = $fopen("bench/fetch_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open bench/fetch_stimulus.txt");
            tb_errors = tb_errors + 1;
        end else begin
            done = 1'b0;
            while (!done) begin
                n = $fscanf(fd, "%s", tok);
                if (n != 1) begin
                    done = 1'b1;
                end else if (tok == "#") begin
                    n = $fgets(line_buf, fd);
                end else if (tok == "M") begin
                    n = $fscanf(fd, "%h %h", a, b);
                    img_addr_q.push_back(a);
                    img_data_q.push_back(b[7:0]);
                end else if (tok == "S" || tok == "B" || tok == "R") begin
                    a = 0;
                    b = 0;
                    if (tok == "S") begin
                        n = $fscanf(fd, "%d %d", a, b);
                    end else if (tok == "B") begin
                        n = $fscanf(fd, "%d %h", a, b);
                    end
                    cmd_op_q.push_back(tok);
                    cmd_a_q.push_back(a);
                    cmd_b_q.push_back(b);
                end else begin
                    $display("unknown record %0s in the stimulus file", tok);
                    tb_errors = tb_errors + 1;
                    done = 1'b1;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_command(input logic [8*8-1:0] op, input int a, input int b);
        int on_len;
        int off_len;
        if (op == "S") begin
            stall_i <= a[0];
            repeat (b) @(posedge clk);
        end else if (op == "B") begin
            repeat (a) @(posedge clk);
            branch_i      <= 1'b1;
            branch_addr_i <= b;
            @(posedge clk);
            branch_i <= 1'b0;
        end else begin
            on_len  = 1 + ($unsigned($random(seed)) % 8);
            off_len = 1 + ($unsigned($random(seed)) % 24);
            stall_i <= 1'b1;
            repeat (on_len) @(posedge clk);
            stall_i <= 1'b0;
            repeat (off_len) @(posedge clk);
        end
    endtask

    initial begin
        int i;
        reset_i       = 1'b1;
        stall_i       = 1'b1;
        branch_i      = 1'b0;
        branch_addr_i = '0;
        load_we_i     = 1'b0;
        load_addr_i   = '0;
        load_data_i   = 8'h00;
        tb_errors     = 0;
        limit_ready   = 1'b0;
        seed          = 32'h56d8_9d2e;
        read_stimulus();
        limit_cycles = 40 * cmd_op_q.size() + 8 * (`FETCH_RAM_DEPTH + img_addr_q.size()) + 16;
        limit_ready  = 1'b1;
        repeat (3) @(posedge clk);
        reset_i <= 1'b0;

        // stall stays high while the RAM is loaded
        for (i = 0; i < `FETCH_RAM_DEPTH; i++) begin
            load_we_i   <= 1'b1;
            load_addr_i <= i;
            load_data_i <= fill_byte(i[7:0]);
            @(posedge clk);
        end
        for (i = 0; i < img_addr_q.size(); i++) begin
            load_addr_i <= img_addr_q[i];
            load_data_i <= img_data_q[i];
            @(posedge clk);
        end
        load_we_i <= 1'b0;

        for (i = 0; i < cmd_op_q.size(); i++) begin
            run_command(cmd_op_q[i], cmd_a_q[i], cmd_b_q[i]);
        end
        repeat (10) @(posedge clk);
        @(negedge clk);

        if (item_count == 0) begin
            $display("no instruction reached the decode outputs");
            tb_errors = tb_errors + 1;
        end
        if (target_pending) begin
            $display("the last branch target never reached the decode outputs");
            tb_errors = tb_errors + 1;
        end
        $display("errors: %0d, items delivered: %0d", error_count + tb_errors, item_count);
        if (error_count + tb_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // watchdog budget is set once the stimulus file is read
    initial begin
        wait (limit_ready === 1'b1);
        repeat (limit_cycles) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", limit_cycles);
        $display("errors: %0d, items delivered: %0d", error_count + tb_errors, item_count);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: fetch_subsys.f
+incdir+rtl
rtl/fetch_pkg.sv
rtl/byte_mem_if.sv
rtl/inst_fetch.sv
rtl/inst_byte_ram.sv
rtl/if_id_reg.sv
rtl/fetch_top.sv
bench/fetch_checker.sv
bench/fetch_tb.sv

// File: bench/fetch_stimulus.txt
# M <addr hex> <byte hex>       image byte written through the load port
# S <0|1> <cycles dec>          stall off or on for a number of cycles
# B <cycles dec> <target hex>   branch strobe after a number of cycles
# R                             random stall burst then a random free run
M 00 93
M 01 00
M 02 50
M 03 00
M 04 13
M 05 01
M 06 a0
M 07 00
M 40 b3
M 41 81
M 42 20
M 43 00
M 44 e3
M 45 0e
M 46 00
M 47 fe
S 0 30
S 1 12
S 0 20
B 5 40
S 0 25
S 1 8
B 3 80
S 1 6
S 0 20
R
R
R
R
B 7 44
R
R
S 0 30
